// ==== hdl/core_types_pkg.sv ====
// ------------------------------
// Core-wide widths and types for physical registers,
// ROB indices, PRF banks and the writeback bus
// ------------------------------
`default_nettype none

package core_types_pkg;

    // Physical register file
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // Reorder buffer
    localparam int ROB_ENTRIES = 64;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    // PRF banking, bank is the low bits of the register number
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [31:0] word_t;

    // One bank's slot on the writeback bus
    typedef struct packed {
        logic      valid;
        upper_pr_t upper_pr;
    } wb_bus_t;

endpackage

`default_nettype wire

// ==== hdl/mdu_divider.sv ====
// ------------------------------
// Iterative radix-2 restoring divider
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_divider
    import core_types_pkg::*, mdu_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,

    input  logic  start,
    input  logic  is_signed,
    input  word_t dividend,
    input  word_t divisor,
    input  logic  accept,

    output logic  done,
    output word_t quotient,
    output word_t remainder
);
    div_state_t  state;
    logic [4:0]  step;

    word_t       dividend_q, divisor_q;
    logic        signed_q;
    word_t       quo_acc, rem_acc;

    logic        div_by_zero, overflow;
    logic        a_neg, b_neg;
    word_t       a_mag, b_mag;
    word_t       src_quo, src_rem;
    logic [32:0] shifted;
    logic        quo_bit;
    word_t       next_quo, next_rem;

    // Special cases are resolved at start without iterating
    assign div_by_zero = (divisor == '0);
    assign overflow = is_signed & (dividend == 32'h8000_0000) & (divisor == 32'hffff_ffff);

    // Magnitudes of the latched operands
    assign a_neg = signed_q & dividend_q[31];
    assign b_neg = signed_q & divisor_q[31];
    assign a_mag = a_neg ? -dividend_q : dividend_q;
    assign b_mag = b_neg ? -divisor_q : divisor_q;

    // ------------------------------
    // One shift-subtract step
    always_comb begin
        src_quo = (step == '0) ? a_mag : quo_acc;
        src_rem = (step == '0) ? '0 : rem_acc;
        shifted = {src_rem, src_quo[31]};
        quo_bit = (shifted >= {1'b0, b_mag});
        if (quo_bit) begin
            next_rem = shifted[31:0] - b_mag;
        end else begin
            next_rem = shifted[31:0];
        end
        next_quo = {src_quo[30:0], quo_bit};
    end

    // ------------------------------
    // Control FSM
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            state <= DIV_IDLE;
            step <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        step <= '0;
                        state <= (div_by_zero | overflow) ? DIV_DONE : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (accept) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge CLK) begin
        if (state == DIV_IDLE && start) begin
            dividend_q <= dividend;
            divisor_q <= divisor;
            signed_q <= is_signed;
            if (div_by_zero) begin
                quo_acc <= '1;
                rem_acc <= dividend;
            end else if (overflow) begin
                quo_acc <= dividend;
                rem_acc <= '0;
            end
        end else if (state == DIV_RUN) begin
            if (step == 5'd31) begin
                // Sign fix on the last step
                quo_acc <= (a_neg ^ b_neg) ? -next_quo : next_quo;
                rem_acc <= a_neg ? -next_rem : next_rem;
            end else begin
                quo_acc <= next_quo;
                rem_acc <= next_rem;
            end
        end
    end

    assign done = (state == DIV_DONE);
    assign quotient = quo_acc;
    assign remainder = rem_acc;

endmodule

`default_nettype wire

// ==== hdl/mdu_multiplier.sv ====
// ------------------------------
// 32x32 multiply, all RISC-V M sign forms
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier
    import core_types_pkg::*, mdu_pkg::*;
(
    input  mdu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   product_word
);
    logic        a_signed, b_signed;
    logic [32:0] a_ext, b_ext;
    logic [65:0] product;

    // MULH is signed-signed, MULHSU signed-unsigned, MULHU unsigned
    assign a_signed = (op == MULH) | (op == MULHSU);
    assign b_signed = (op == MULH);

    // One extra bit lets a single signed multiply cover all forms
    assign a_ext = {a_signed & a[31], a};
    assign b_ext = {b_signed & b[31], b};

    assign product = $signed(a_ext) * $signed(b_ext);

    always_comb begin
        if (op == MUL) begin
            product_word = product[31:0];
        end else begin
            product_word = product[63:32];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mdu_operand_collect.sv ====
// ------------------------------
// Operand-collect stage, holds one operation
// until both operands are present
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_operand_collect
    import core_types_pkg::*, mdu_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    input  logic       issue_valid,
    input  mdu_issue_t issue,
    output logic       issue_ready,

    input  logic       A_reg_read_ack,
    input  logic       A_reg_read_port,
    input  logic       B_reg_read_ack,
    input  logic       B_reg_read_port,
    input  word_t      reg_read_data [PRF_BANK_COUNT-1:0][1:0],
    input  word_t      forward_data [PRF_BANK_COUNT-1:0],

    input  logic       stall_wb,
    output logic       exec_valid,
    output mdu_exec_t  exec
);
    logic       valid_oc;
    logic       first_oc;
    mdu_issue_t held;

    logic       a_saved, b_saved;
    word_t      a_saved_data, b_saved_data;

    logic       a_arrive, b_arrive;
    logic       a_present, b_present;
    word_t      a_data, b_data;
    logic       launch;

    // Forward data only counts in the first cycle in collect
    assign a_arrive = (held.a.forward & first_oc) | A_reg_read_ack;
    assign b_arrive = (held.b.forward & first_oc) | B_reg_read_ack;

    assign a_present = held.a.is_zero | a_saved | a_arrive;
    assign b_present = held.b.is_zero | b_saved | b_arrive;

    assign launch = valid_oc & a_present & b_present & ~stall_wb;
    assign issue_ready = ~valid_oc | launch;

    // Operand data select
    always_comb begin
        if (held.a.is_zero) begin
            a_data = '0;
        end else if (a_saved) begin
            a_data = a_saved_data;
        end else if (held.a.forward & first_oc) begin
            a_data = forward_data[held.a.pr[LOG_PRF_BANK_COUNT-1:0]];
        end else begin
            a_data = reg_read_data[held.a.pr[LOG_PRF_BANK_COUNT-1:0]][A_reg_read_port];
        end

        if (held.b.is_zero) begin
            b_data = '0;
        end else if (b_saved) begin
            b_data = b_saved_data;
        end else if (held.b.forward & first_oc) begin
            b_data = forward_data[held.b.pr[LOG_PRF_BANK_COUNT-1:0]];
        end else begin
            b_data = reg_read_data[held.b.pr[LOG_PRF_BANK_COUNT-1:0]][B_reg_read_port];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            valid_oc <= 1'b0;
            first_oc <= 1'b0;
            a_saved <= 1'b0;
            b_saved <= 1'b0;
        end else if (issue_ready) begin
            valid_oc <= issue_valid;
            first_oc <= 1'b1;
            a_saved <= 1'b0;
            b_saved <= 1'b0;
        end else begin
            first_oc <= 1'b0;
            a_saved <= a_saved | a_arrive;
            b_saved <= b_saved | b_arrive;
        end
    end

    // Payload, latched while the operation waits
    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            held <= issue;
        end
        if (a_arrive & ~a_saved) begin
            a_saved_data <= a_data;
        end
        if (b_arrive & ~b_saved) begin
            b_saved_data <= b_data;
        end
    end

    assign exec_valid = launch;
    assign exec = '{
        op:        held.op,
        a_pr:      held.a.pr,
        b_pr:      held.b.pr,
        a_data:    a_data,
        b_data:    b_data,
        dest_pr:   held.dest_pr,
        rob_index: held.rob_index
    };

endmodule

`default_nettype wire

// ==== hdl/mdu_pipeline.sv ====
// ------------------------------
// MDU pipeline top, writeback stage and stall control
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_pipeline
    import core_types_pkg::*, mdu_pkg::*;
#(
    parameter int RESULT_CACHE_ENTRIES = 4
) (
    input  logic       CLK,
    input  logic       nRST,

    input  logic       issue_valid,
    input  mdu_issue_t issue,
    output logic       issue_ready,

    input  logic       A_reg_read_ack,
    input  logic       A_reg_read_port,
    input  logic       B_reg_read_ack,
    input  logic       B_reg_read_port,
    input  word_t      reg_read_data [PRF_BANK_COUNT-1:0][1:0],
    input  word_t      forward_data [PRF_BANK_COUNT-1:0],
    input  wb_bus_t    wb_bus [PRF_BANK_COUNT-1:0],

    output logic       WB_valid,
    output mdu_wb_t    wb,
    input  logic       WB_ready
);
    logic      exec_valid;
    mdu_exec_t exec;
    logic      stall_wb;

    logic      valid_wb;
    mdu_exec_t exec_wb;
    logic      is_div;

    word_t     product_word;
    logic      div_start, div_accept, div_done, div_busy;
    word_t     div_quotient, div_remainder;
    logic      hit;
    word_t     hit_quotient, hit_remainder;

    mdu_operand_collect i_collect (
        .CLK, .nRST,
        .issue_valid, .issue, .issue_ready,
        .A_reg_read_ack, .A_reg_read_port, .B_reg_read_ack, .B_reg_read_port,
        .reg_read_data, .forward_data,
        .stall_wb, .exec_valid, .exec
    );

    // ------------------------------
    // Writeback stage
    assign is_div = exec_wb.op[2];
    assign stall_wb = valid_wb & (~WB_ready | (is_div & ~(hit | div_done)));

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            valid_wb <= 1'b0;
        end else if (~stall_wb) begin
            valid_wb <= exec_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_wb) begin
            exec_wb <= exec;
        end
    end

    mdu_multiplier i_mul (.op(exec_wb.op), .a(exec_wb.a_data), .b(exec_wb.b_data), .product_word);

    // Divider runs only on a cache miss
    assign div_start = valid_wb & is_div & ~hit & ~div_busy;
    assign div_accept = WB_valid & WB_ready & is_div & ~hit;

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            div_busy <= 1'b0;
        end else if (div_start) begin
            div_busy <= 1'b1;
        end else if (div_accept) begin
            div_busy <= 1'b0;
        end
    end

    mdu_divider i_div (
        .CLK, .nRST, .start(div_start), .is_signed(~exec_wb.op[0]),
        .dividend(exec_wb.a_data), .divisor(exec_wb.b_data), .accept(div_accept),
        .done(div_done), .quotient(div_quotient), .remainder(div_remainder)
    );

    mdu_result_cache #(.RESULT_CACHE_ENTRIES(RESULT_CACHE_ENTRIES)) i_cache (
        .CLK, .nRST,
        .lookup_a_pr(exec_wb.a_pr), .lookup_b_pr(exec_wb.b_pr),
        .lookup_unsigned(exec_wb.op[0]), .wb_bus,
        .fill(div_accept), .fill_quotient(div_quotient), .fill_remainder(div_remainder),
        .hit, .hit_quotient, .hit_remainder
    );

    // ------------------------------
    // Result select
    assign WB_valid = valid_wb & (~is_div | hit | div_done);

    always_comb begin
        if (~is_div) begin
            wb.data = product_word;
        end else if (hit) begin
            wb.data = exec_wb.op[1] ? hit_remainder : hit_quotient;
        end else begin
            wb.data = exec_wb.op[1] ? div_remainder : div_quotient;
        end
        wb.dest_pr = exec_wb.dest_pr;
        wb.rob_index = exec_wb.rob_index;
    end

endmodule

`default_nettype wire

// ==== hdl/mdu_pkg.sv ====
// ------------------------------
// MDU opcodes, divider states and pipeline structs
// ------------------------------
`default_nettype none

package mdu_pkg;

    import core_types_pkg::*;

    // RISC-V funct3 order
    // Bit 2 is divide, bit 1 remainder, bit 0 unsigned
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } mdu_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    // ------------------------------
    // Pipeline payloads

    typedef struct packed {
        logic forward;
        logic is_zero;
        pr_t  pr;
    } mdu_operand_t;

    typedef struct packed {
        mdu_op_t      op;
        mdu_operand_t a;
        mdu_operand_t b;
        pr_t          dest_pr;
        rob_idx_t     rob_index;
    } mdu_issue_t;

    typedef struct packed {
        mdu_op_t  op;
        pr_t      a_pr;
        pr_t      b_pr;
        word_t    a_data;
        word_t    b_data;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } mdu_exec_t;

    typedef struct packed {
        word_t    data;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } mdu_wb_t;

endpackage

`default_nettype wire

// ==== hdl/mdu_result_cache.sv ====
// ------------------------------
// Divide result cache with writeback-bus invalidation
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_result_cache
    import core_types_pkg::*;
#(
    parameter int RESULT_CACHE_ENTRIES = 4
) (
    input  logic    CLK,
    input  logic    nRST,

    input  pr_t     lookup_a_pr,
    input  pr_t     lookup_b_pr,
    input  logic    lookup_unsigned,
    input  wb_bus_t wb_bus [PRF_BANK_COUNT-1:0],

    input  logic    fill,
    input  word_t   fill_quotient,
    input  word_t   fill_remainder,

    output logic    hit,
    output word_t   hit_quotient,
    output word_t   hit_remainder
);
    localparam int IDX_W = (RESULT_CACHE_ENTRIES > 1) ? $clog2(RESULT_CACHE_ENTRIES) : 1;

    typedef struct packed {
        pr_t   a_pr;
        pr_t   b_pr;
        logic  is_unsigned;
        word_t quotient;
        word_t remainder;
    } cache_entry_t;

    logic         valid [RESULT_CACHE_ENTRIES];
    cache_entry_t entry [RESULT_CACHE_ENTRIES];
    logic [IDX_W-1:0] fill_idx;

    // True when the bus announces a write to this register
    function automatic logic wb_names(input pr_t pr, input wb_bus_t bus [PRF_BANK_COUNT-1:0]);
        wb_bus_t slot;
        slot = bus[pr[LOG_PRF_BANK_COUNT-1:0]];
        return slot.valid & (slot.upper_pr == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            fill_idx <= '0;
            for (int i = 0; i < RESULT_CACHE_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RESULT_CACHE_ENTRIES; i++) begin
                if (wb_names(entry[i].a_pr, wb_bus) | wb_names(entry[i].b_pr, wb_bus)) begin
                    valid[i] <= 1'b0;
                end
            end
            if (fill) begin
                // A source overwritten this very cycle leaves the entry stale
                valid[fill_idx] <= ~(wb_names(lookup_a_pr, wb_bus)
                                     | wb_names(lookup_b_pr, wb_bus));
                fill_idx <= (fill_idx == IDX_W'(RESULT_CACHE_ENTRIES - 1)) ? '0 : fill_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            entry[fill_idx] <= '{lookup_a_pr, lookup_b_pr, lookup_unsigned,
                                 fill_quotient, fill_remainder};
        end
    end

    // Lookup keyed on both registers and signedness
    always_comb begin
        hit = 1'b0;
        hit_quotient = entry[0].quotient;
        hit_remainder = entry[0].remainder;
        for (int i = 0; i < RESULT_CACHE_ENTRIES; i++) begin
            if (valid[i] && entry[i].a_pr == lookup_a_pr && entry[i].b_pr == lookup_b_pr
                    && entry[i].is_unsigned == lookup_unsigned) begin
                hit = 1'b1;
                hit_quotient = entry[i].quotient;
                hit_remainder = entry[i].remainder;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mdu_pipeline.f ====
hdl/core_types_pkg.sv
hdl/mdu_pkg.sv
hdl/mdu_operand_collect.sv
hdl/mdu_multiplier.sv
hdl/mdu_divider.sv
hdl/mdu_result_cache.sv
hdl/mdu_pipeline.sv
tests/tb_clock_gen.sv
tests/mdu_pipeline_checker.sv
tests/tb_mdu_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MDU pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mdu_pipeline \
    -f mdu_pipeline.f -o tb_mdu_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_mdu_pipeline)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// ==== tests/mdu_pipeline_checker.sv ====
// ------------------------------
// Concurrent assertions on the MDU pipeline outputs
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mdu_pipeline_checker
    import core_types_pkg::*, mdu_pkg::*;
(
    input logic    CLK,
    input logic    nRST,
    input logic    WB_valid,
    input logic    WB_ready,
    input logic    issue_valid,
    input logic    issue_ready,
    input mdu_wb_t wb
);
    a_wb_idle_in_reset: assert property (@(posedge CLK) !nRST |-> !WB_valid)
        else $error("WB_valid high during reset");

    // Back-pressure must freeze the result
    a_wb_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (WB_valid && !WB_ready) |=> (WB_valid && $stable(wb)))
        else $error("wb changed while stalled by WB_ready");

    // An empty collect stage stays ready until an issue arrives
    a_ready_when_empty: assert property (@(posedge CLK) disable iff (!nRST)
        (issue_ready && !issue_valid) |=> issue_ready)
        else $error("issue_ready dropped with no issue accepted");

endmodule

bind mdu_pipeline mdu_pipeline_checker i_checker (
    .CLK, .nRST, .WB_valid, .WB_ready, .issue_valid, .issue_ready, .wb
);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// ------------------------------
// Testbench clock and reset generator
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD = 50,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_mdu_pipeline.sv ====
// ------------------------------
// Table-driven MDU testbench with PRF model,
// reference results and compare tasks
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mdu_pipeline
    import core_types_pkg::*, mdu_pkg::*;
;
    localparam int NUM_ROWS = 20;
    localparam int CYCLE_LIMIT = 60 * NUM_ROWS + 50;

    typedef enum logic [1:0] {SRC_ZERO, SRC_FWD, SRC_ACK} src_t;

    typedef struct {
        mdu_op_t op;
        pr_t     a_pr, b_pr;
        word_t   a_val, b_val;
        src_t    a_src, b_src;
        int      a_delay, b_delay;
        int      hold;
    } row_t;

    typedef struct {
        word_t    data;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } exp_t;

    logic       CLK, nRST;
    logic       issue_valid, issue_ready;
    mdu_issue_t issue;
    logic       A_reg_read_ack, A_reg_read_port, B_reg_read_ack, B_reg_read_port;
    word_t      reg_read_data [PRF_BANK_COUNT-1:0][1:0];
    word_t      forward_data [PRF_BANK_COUNT-1:0];
    wb_bus_t    wb_bus [PRF_BANK_COUNT-1:0];
    logic       WB_valid, WB_ready;
    mdu_wb_t    wb;

    row_t  rows [NUM_ROWS];
    int    row_count = 0;
    word_t regs [PR_COUNT];
    exp_t  expected [$];
    exp_t  mon_exp;
    int    issued_count = 0;
    int    received_count = 0;
    int    error_count = 0;
    int    cycles = 0;
    int    seed = 9;

    tb_clock_gen #(.HALF_PERIOD(50), .RESET_CYCLES(4)) i_clk (.CLK, .nRST);

    mdu_pipeline #(.RESULT_CACHE_ENTRIES(4)) i_dut (
        .CLK, .nRST, .issue_valid, .issue, .issue_ready,
        .A_reg_read_ack, .A_reg_read_port, .B_reg_read_ack, .B_reg_read_port,
        .reg_read_data, .forward_data, .wb_bus, .WB_valid, .wb, .WB_ready
    );

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_tag(input pr_t got_pr, input pr_t exp_pr,
                             input rob_idx_t got_rob, input rob_idx_t exp_rob);
        if (got_pr !== exp_pr || got_rob !== exp_rob) begin
            report_failure($sformatf("CHECK FAILED at %0t: tag got %0d/%0d expected %0d/%0d",
                                     $time, got_pr, got_rob, exp_pr, exp_rob));
        end
    endtask

    // RISC-V M results, computed on 64-bit unsigned operands
    function automatic word_t ref_result(input mdu_op_t op, input word_t a, input word_t b);
        logic [63:0] full;
        logic        ovf;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MUL: begin
                full = {32'b0, a} * {32'b0, b};
                return full[31:0];
            end
            MULH: begin
                full = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                return full[63:32];
            end
            MULHSU: begin
                full = {{32{a[31]}}, a} * {32'b0, b};
                return full[63:32];
            end
            MULHU: begin
                full = {32'b0, a} * {32'b0, b};
                return full[63:32];
            end
            DIV:    return (b == 0) ? '1 : ovf ? a : word_t'($signed(a) / $signed(b));
            DIVU:   return (b == 0) ? '1 : a / b;
            REM:    return (b == 0) ? a : ovf ? '0 : word_t'($signed(a) % $signed(b));
            default: return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic add_row(input mdu_op_t op, input pr_t a_pr, input word_t a_val,
                           input src_t a_src, input int a_delay, input pr_t b_pr,
                           input word_t b_val, input src_t b_src, input int b_delay,
                           input int hold);
        rows[row_count] = '{op, a_pr, b_pr, a_val, b_val, a_src, b_src, a_delay, b_delay, hold};
        row_count++;
    endtask

    task automatic drain();
        while (received_count != issued_count) @(negedge CLK);
    endtask

    // New register value, announced on the writeback bus for one cycle
    task automatic announce_write(input pr_t pr, input word_t value);
        @(posedge CLK);
        wb_bus[pr[1:0]] <= '{valid: 1'b1, upper_pr: pr[5:2]};
        regs[pr] = value;
        @(posedge CLK);
        wb_bus[pr[1:0]] <= '{valid: 1'b0, upper_pr: '0};
    endtask

    task automatic scramble_forward(input row_t r);
        if (r.a_src == SRC_FWD) forward_data[r.a_pr[1:0]] <= ~regs[r.a_pr];
        if (r.b_src == SRC_FWD) forward_data[r.b_pr[1:0]] <= ~regs[r.b_pr];
    endtask

    // WB_ready low for a few cycles, output must not move
    task automatic hold_output(input int hold);
        mdu_wb_t snap;
        do @(negedge CLK); while (!WB_valid);
        snap = wb;
        for (int h = 0; h < hold; h++) begin
            @(negedge CLK);
            check_data(wb.data, snap.data, "held data");
            check_tag(wb.dest_pr, snap.dest_pr, wb.rob_index, snap.rob_index);
            if (!WB_valid) begin
                report_failure("WB_valid dropped while WB_ready was low");
            end
        end
        @(posedge CLK);
        WB_ready <= 1'b1;
    endtask

    task automatic run_row(input int i);
        row_t       r;
        mdu_issue_t iss;
        exp_t       e;
        int         maxd;
        int         rnd;
        r = rows[i];
        if (r.a_src != SRC_ZERO && regs[r.a_pr] != r.a_val) begin
            drain();
            announce_write(r.a_pr, r.a_val);
        end
        if (r.b_src != SRC_ZERO && regs[r.b_pr] != r.b_val) begin
            drain();
            announce_write(r.b_pr, r.b_val);
        end
        if (r.hold > 0) drain();
        e.data = ref_result(r.op, (r.a_src == SRC_ZERO) ? '0 : r.a_val,
                            (r.b_src == SRC_ZERO) ? '0 : r.b_val);
        e.dest_pr = pr_t'(32 + i);
        e.rob_index = rob_idx_t'(3 * i);
        expected.push_back(e);
        iss.op = r.op;
        iss.a = '{forward: r.a_src == SRC_FWD, is_zero: r.a_src == SRC_ZERO, pr: r.a_pr};
        iss.b = '{forward: r.b_src == SRC_FWD, is_zero: r.b_src == SRC_ZERO, pr: r.b_pr};
        iss.dest_pr = e.dest_pr;
        iss.rob_index = e.rob_index;
        @(posedge CLK);
        issue_valid <= 1'b1;
        issue <= iss;
        do @(negedge CLK); while (!issue_ready);
        // Acceptance edge
        @(posedge CLK);
        issue_valid <= 1'b0;
        issued_count++;
        if (r.hold > 0) WB_ready <= 1'b0;
        maxd = (r.a_delay > r.b_delay) ? r.a_delay : r.b_delay;
        for (int k = 0; k <= maxd; k++) begin
            if (k > 0) @(posedge CLK);
            if (k == 0) begin
                if (r.a_src == SRC_FWD) forward_data[r.a_pr[1:0]] <= regs[r.a_pr];
                if (r.b_src == SRC_FWD) forward_data[r.b_pr[1:0]] <= regs[r.b_pr];
            end else if (k == 1) begin
                scramble_forward(r);
            end
            A_reg_read_ack <= (r.a_src == SRC_ACK) && (r.a_delay == k);
            B_reg_read_ack <= (r.b_src == SRC_ACK) && (r.b_delay == k);
            if (r.a_src == SRC_ACK && r.a_delay == k) begin
                rnd = $random(seed);
                A_reg_read_port <= rnd[0];
                reg_read_data[r.a_pr[1:0]][rnd[0]] <= regs[r.a_pr];
            end
            if (r.b_src == SRC_ACK && r.b_delay == k) begin
                rnd = $random(seed);
                B_reg_read_port <= rnd[0];
                reg_read_data[r.b_pr[1:0]][rnd[0]] <= regs[r.b_pr];
            end
        end
        @(posedge CLK);
        A_reg_read_ack <= 1'b0;
        B_reg_read_ack <= 1'b0;
        scramble_forward(r);
        if (r.hold > 0) hold_output(r.hold);
    endtask

    // Cycle limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    // Results in issue order
    always @(negedge CLK) begin
        if (nRST && WB_valid && WB_ready) begin
            if (expected.size() == 0) begin
                report_failure("A result appeared with no operation outstanding");
            end else begin
                mon_exp = expected.pop_front();
                check_data(wb.data, mon_exp.data, "result data");
                check_tag(wb.dest_pr, mon_exp.dest_pr, wb.rob_index, mon_exp.rob_index);
                received_count++;
            end
        end
    end

    initial begin
        word_t r1, r2, r3, r4, r5, r6, r7;
        issue_valid = 1'b0;
        issue = '0;
        A_reg_read_ack = 1'b0;
        A_reg_read_port = 1'b0;
        B_reg_read_ack = 1'b0;
        B_reg_read_port = 1'b0;
        WB_ready = 1'b1;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            forward_data[b] = '0;
            reg_read_data[b][0] = '0;
            reg_read_data[b][1] = '0;
            wb_bus[b] = '{valid: 1'b0, upper_pr: '0};
        end
        // Register 0 stays zero, zero operands name it
        for (int p = 0; p < PR_COUNT; p++) regs[p] = '0;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed) | 32'h8000_0000;
        r4 = $random(seed) & 32'h0000_ffff;
        r5 = $random(seed);
        r6 = $random(seed);
        r7 = $random(seed);

        // ------------------------------
        // Stimulus table
        add_row(MUL,    5, 32'h8000_0000, SRC_FWD, 0, 6, 32'hffff_ffff, SRC_FWD, 0, 0);
        add_row(MULH,   5, 32'h8000_0000, SRC_FWD, 0, 6, 32'hffff_ffff, SRC_ACK, 1, 0);
        add_row(MULHSU, 5, 32'h8000_0000, SRC_ACK, 0, 6, 32'hffff_ffff, SRC_FWD, 0, 0);
        add_row(MULHU,  5, 32'h8000_0000, SRC_ACK, 2, 6, 32'hffff_ffff, SRC_ACK, 0, 0);
        add_row(MUL,    9, r1, SRC_ACK, 2, 10, r2, SRC_ACK, 0, 0);
        add_row(MULH,   9, r1, SRC_FWD, 0, 10, r2, SRC_ACK, 3, 0);
        add_row(DIV,   13, r3, SRC_FWD, 0, 14, r4, SRC_FWD, 0, 0);
        add_row(DIVU,  13, r3, SRC_ACK, 1, 14, r4, SRC_FWD, 0, 0);
        add_row(REM,   13, r3, SRC_FWD, 0, 14, r4, SRC_ACK, 2, 0);
        add_row(REMU,  13, r3, SRC_ACK, 0, 14, r4, SRC_ACK, 0, 0);
        add_row(DIV,   17, r5, SRC_FWD, 0, 0, '0, SRC_ZERO, 0, 0);
        add_row(REMU,  17, r5, SRC_ACK, 1, 0, '0, SRC_ZERO, 0, 0);
        add_row(DIV,   21, 32'h8000_0000, SRC_FWD, 0, 22, 32'hffff_ffff, SRC_FWD, 0, 0);
        add_row(REM,   21, 32'h8000_0000, SRC_ACK, 0, 22, 32'hffff_ffff, SRC_FWD, 0, 0);
        add_row(DIVU,  13, r6, SRC_FWD, 0, 14, r4, SRC_FWD, 0, 0);
        add_row(REM,   13, r6, SRC_ACK, 1, 14, r4, SRC_FWD, 0, 5);
        add_row(MUL,    0, '0, SRC_ZERO, 0, 26, r7, SRC_FWD, 0, 0);
        add_row(DIVU,  25, r7, SRC_FWD, 0, 26, r7 >> 7, SRC_ACK, 1, 3);
        add_row(MULHU, 29, r2, SRC_ACK, 3, 30, r5, SRC_ACK, 1, 0);
        add_row(DIV,   13, r6, SRC_ACK, 0, 14, r4 + 1, SRC_ACK, 2, 0);

        wait (nRST === 1'b1);
        for (int i = 0; i < row_count; i++) begin
            run_row(i);
        end
        drain();
        @(posedge CLK);
        if (error_count == 0 && expected.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
